//--- rtl/adder_tree_pkg.sv
// lanes are lane_width bits wide, so a LANE_W above lane_width does not fit the pair word

package adder_tree_pkg;

    // ***********************************************************************
    // tree shape
    // ***********************************************************************

    // operands per strobe, the last one is the odd element
    localparam int num_elements = 25;

    // default element width, also the width of each lane in a pair word
    localparam int lane_width = 16;

    // pair-adding levels before the lane fold
    localparam int num_stages = 4;

    // input words per level
    // level 2 gets three results from level 1 plus the odd-element word
    localparam int stage_words [num_stages] = '{12, 6, 4, 2};

    // ***********************************************************************
    // timing
    // ***********************************************************************

    // cycles through one adder level, and through the fold
    localparam int stage_latency = 2;

    // odd element waits two level latencies after capture
    localparam int odd_delay = 4;

    // ***********************************************************************
    // pair word
    // ***********************************************************************

    // raw view for slicing the operand vector, lane view for the adders
    typedef union packed {
        logic [2*lane_width-1:0] raw;
        struct packed {
            logic [lane_width-1:0] hi;
            logic [lane_width-1:0] lo;
        } lane;
    } lane_pair_t;

endpackage

//--- rtl/operand_capture.sv
// operands are sampled only on data_v, and element 24 rides a free-running delay line

`timescale 1ns/100ps

module operand_capture #(
    parameter int LANE_W = adder_tree_pkg::lane_width
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           data_v,
    input  logic [adder_tree_pkg::num_elements*LANE_W-1:0] in_add,
    output adder_tree_pkg::lane_pair_t                     pair_words [adder_tree_pkg::num_elements/2],
    output logic                                           pair_v,
    output adder_tree_pkg::lane_pair_t                     odd_word
);

    // elements j and j+pairs share one pair word
    localparam int pairs   = adder_tree_pkg::num_elements / 2;
    localparam int odd_idx = adder_tree_pkg::num_elements - 1;
    localparam int dly_n   = adder_tree_pkg::odd_delay;

    // captured odd element and its delay line
    logic [LANE_W-1:0] odd_q;
    logic [LANE_W-1:0] odd_dly [dly_n];

    // element lo goes to the low lane, element hi to the high lane
    // unused top bits of each lane stay zero when LANE_W is narrow
    function automatic adder_tree_pkg::lane_pair_t pack_pair(
        input logic [LANE_W-1:0] lo,
        input logic [LANE_W-1:0] hi
    );
        adder_tree_pkg::lane_pair_t w;
        w.raw = '0;
        w.raw[LANE_W-1:0] = lo;
        w.raw[adder_tree_pkg::lane_width +: LANE_W] = hi;
        return w;
    endfunction

    // ***********************************************************************
    // capture on the strobe
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int j = 0; j < pairs; j++) begin
                pair_words[j] <= '0;
            end
            odd_q  <= '0;
            pair_v <= 1'b0;
        end else begin
            // one cycle valid, data held until the next strobe
            pair_v <= data_v;
            if (data_v) begin
                for (int j = 0; j < pairs; j++) begin
                    pair_words[j] <= pack_pair(in_add[j*LANE_W +: LANE_W],
                                               in_add[(j+pairs)*LANE_W +: LANE_W]);
                end
                odd_q <= in_add[odd_idx*LANE_W +: LANE_W];
            end
        end
    end

    // ***********************************************************************
    // odd element delay
    // ***********************************************************************

    // shifts every cycle, so back-to-back strobes keep their own odd values
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < dly_n; i++) begin
                odd_dly[i] <= '0;
            end
        end else begin
            odd_dly[0] <= odd_q;
            for (int i = 1; i < dly_n; i++) begin
                odd_dly[i] <= odd_dly[i-1];
            end
        end
    end

    // high lane of the odd word is always zero
    assign odd_word = pack_pair(odd_dly[dly_n-1], '0);

    // valid must be clean once out of reset, the whole tree keys off it
    a_pair_v_known: assert property (@(posedge clk) disable iff (!rst) !$isunknown(pair_v));

endmodule

//--- rtl/lane_add_stage.sv
// fixed two-cycle level with no stall, each lane wraps on its own carry

`timescale 1ns/100ps

module lane_add_stage #(
    parameter int LANE_W   = adder_tree_pkg::lane_width,
    parameter int IN_WORDS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  adder_tree_pkg::lane_pair_t in_words [IN_WORDS],
    input  logic                       in_v,
    output adder_tree_pkg::lane_pair_t out_words [IN_WORDS/2],
    output logic                       out_v
);

    localparam int out_n = IN_WORDS / 2;

    // busy[0] is the incoming valid and enables the adder register
    // busy[1] loads the result, busy[2] marks the result cycle
    logic [1:0] busy_q;
    logic [2:0] busy;

    // first pipeline register, the raw lane sums
    adder_tree_pkg::lane_pair_t sum_q [out_n];

    // two independent lane adds in one word
    // carry out of each lane is dropped, nothing crosses into the high lane
    function automatic adder_tree_pkg::lane_pair_t lane_add(
        input adder_tree_pkg::lane_pair_t a,
        input adder_tree_pkg::lane_pair_t b
    );
        adder_tree_pkg::lane_pair_t r;
        r = '0;
        r.lane.lo[LANE_W-1:0] = a.lane.lo[LANE_W-1:0] + b.lane.lo[LANE_W-1:0];
        r.lane.hi[LANE_W-1:0] = a.lane.hi[LANE_W-1:0] + b.lane.hi[LANE_W-1:0];
        return r;
    endfunction

    // ***********************************************************************
    // busy shift
    // ***********************************************************************

    assign busy = {busy_q, in_v};

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy[1:0];
        end
    end

    assign out_v = busy[2];

    // ***********************************************************************
    // adder and result registers
    // ***********************************************************************

    // word j pairs with word j+out_n
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int j = 0; j < out_n; j++) begin
                sum_q[j] <= '0;
            end
        end else if (busy[0]) begin
            for (int j = 0; j < out_n; j++) begin
                sum_q[j] <= lane_add(in_words[j], in_words[j+out_n]);
            end
        end
    end

    // result stays put until the next set arrives
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int j = 0; j < out_n; j++) begin
                out_words[j] <= '0;
            end
        end else if (busy[1]) begin
            for (int j = 0; j < out_n; j++) begin
                out_words[j] <= sum_q[j];
            end
        end
    end

    // pairing needs an even word count
    a_even_words: assert property (@(posedge clk) (IN_WORDS % 2) == 0);

    // valid comes out exactly two cycles after it goes in, never early or late
    a_lat_fwd: assert property (@(posedge clk) disable iff (!rst) in_v |-> ##2 out_v);
    a_lat_back: assert property (@(posedge clk) disable iff (!rst) out_v |-> $past(in_v, 2));

endmodule

//--- rtl/lane_fold.sv
// output is held until the next word, the sum wraps modulo 2^LANE_W

`timescale 1ns/100ps

module lane_fold #(
    parameter int LANE_W = adder_tree_pkg::lane_width
) (
    input  logic                       clk,
    input  logic                       rst,
    input  adder_tree_pkg::lane_pair_t word,
    input  logic                       word_v,
    output logic [LANE_W-1:0]          sum,
    output logic                       sum_v
);

    // high plus low lane, first register
    logic [LANE_W-1:0] fold_q;
    // valid pipe, bit 1 is the output strobe
    logic [1:0]        v_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            v_q <= '0;
        end else begin
            v_q <= {v_q[0], word_v};
        end
    end

    // the two lane sums become one element sum
    always_ff @(posedge clk) begin
        if (!rst) begin
            fold_q <= '0;
        end else if (word_v) begin
            fold_q <= word.lane.hi[LANE_W-1:0] + word.lane.lo[LANE_W-1:0];
        end
    end

    // registered result for the top-level output
    always_ff @(posedge clk) begin
        if (!rst) begin
            sum <= '0;
        end else if (v_q[0]) begin
            sum <= fold_q;
        end
    end

    assign sum_v = v_q[1];

    // an isolated word gives an isolated one-cycle sum pulse two cycles later
    a_pulse_shape: assert property (@(posedge clk) disable iff (!rst)
        (word_v ##1 !word_v) |-> ##1 (sum_v ##1 !sum_v));

    // no sum pulse without a word two cycles before
    a_no_spurious: assert property (@(posedge clk) disable iff (!rst)
        sum_v |-> $past(word_v, 2));

endmodule

//--- rtl/adder_tree_25.sv
// takes a new set every cycle with no back-pressure, add_res_v comes 11 cycles after data_v

`timescale 1ns/100ps

module adder_tree_25 #(
    parameter int LANE_W = adder_tree_pkg::lane_width
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           data_v,
    input  logic [adder_tree_pkg::num_elements*LANE_W-1:0] in_add,
    output logic [LANE_W-1:0]                              add_res,
    output logic                                           add_res_v
);

    // odd element joins where its delay matches the tree depth
    localparam int odd_stage  = adder_tree_pkg::odd_delay / adder_tree_pkg::stage_latency;
    localparam int last_stage = adder_tree_pkg::num_stages - 1;

    adder_tree_pkg::lane_pair_t pair_words [adder_tree_pkg::num_elements/2];
    adder_tree_pkg::lane_pair_t odd_word;
    logic                       pair_v;

    // ***********************************************************************
    // feeder
    // ***********************************************************************

    operand_capture #(
        .LANE_W (LANE_W)
    ) u_capture (
        .clk        (clk),
        .rst        (rst),
        .data_v     (data_v),
        .in_add     (in_add),
        .pair_words (pair_words),
        .pair_v     (pair_v),
        .odd_word   (odd_word)
    );

    // ***********************************************************************
    // adder levels
    // ***********************************************************************

    for (genvar k = 0; k < adder_tree_pkg::num_stages; k++) begin : tree_level
        localparam int in_n = adder_tree_pkg::stage_words[k];

        adder_tree_pkg::lane_pair_t in_w  [in_n];
        adder_tree_pkg::lane_pair_t out_w [in_n/2];
        logic                       in_v;
        logic                       out_v;

        if (k == 0) begin : g_src
            for (genvar j = 0; j < in_n; j++) begin : g_w
                assign in_w[j] = pair_words[j];
            end
            assign in_v = pair_v;
        end else begin : g_src
            localparam int prev_n = adder_tree_pkg::stage_words[k-1] / 2;
            for (genvar j = 0; j < prev_n; j++) begin : g_w
                assign in_w[j] = tree_level[k-1].out_w[j];
            end
            // odd word fills the extra slot after the previous results
            if (k == odd_stage) begin : g_odd
                assign in_w[prev_n] = odd_word;
            end
            assign in_v = tree_level[k-1].out_v;
        end

        lane_add_stage #(
            .LANE_W   (LANE_W),
            .IN_WORDS (in_n)
        ) u_stage (
            .clk       (clk),
            .rst       (rst),
            .in_words  (in_w),
            .in_v      (in_v),
            .out_words (out_w),
            .out_v     (out_v)
        );
    end

    // ***********************************************************************
    // lane merge
    // ***********************************************************************

    lane_fold #(
        .LANE_W (LANE_W)
    ) u_fold (
        .clk    (clk),
        .rst    (rst),
        .word   (tree_level[last_stage].out_w[0]),
        .word_v (tree_level[last_stage].out_v),
        .sum    (add_res),
        .sum_v  (add_res_v)
    );

endmodule

//--- bench/clock_gen.sv
// clock runs from time zero, rst is released on a falling edge after RST_CYCLES rising edges

`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // active low, held for RST_CYCLES rising edges
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

//--- bench/adder_tree_25_tb.sv
// 16-bit lanes only, results are expected 11 cycles after each strobe with no back-pressure

`timescale 1ns/100ps

module adder_tree_25_tb;

    localparam int lane_w    = 16;
    localparam int n_el      = adder_tree_pkg::num_elements;
    localparam int period    = 20;
    localparam int rst_cyc   = 2;
    // capture, four adder levels, then the fold
    localparam int latency   = 1 + (adder_tree_pkg::num_stages + 1) * 2;
    localparam int hand_rows = 10;
    localparam int num_rows  = hand_rows + 6;
    localparam int lead_idle = 6;
    localparam int drain_max = latency + 10;

    logic                     clk;
    logic                     rst;
    logic                     data_v;
    logic [n_el*lane_w-1:0]   in_add;
    logic [lane_w-1:0]        add_res;
    logic                     add_res_v;

    // ***********************************************************************
    // stimulus table
    // ***********************************************************************

    logic [lane_w-1:0] ops [num_rows][n_el];
    logic [lane_w-1:0] exp_sum [num_rows];
    // idle cycles after each row, 0 means the next row streams right behind
    int                gap [num_rows];
    int                issue_cyc [num_rows];

    int cycle       = 0;
    int issued      = 0;
    int pulses      = 0;
    int passed      = 0;
    int errors      = 0;
    bit table_ready = 1'b0;

    clock_gen #(
        .PERIOD     (period),
        .RST_CYCLES (rst_cyc)
    ) u_clk (
        .clk (clk),
        .rst (rst)
    );

    adder_tree_25 #(
        .LANE_W (lane_w)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .data_v    (data_v),
        .in_add    (in_add),
        .add_res   (add_res),
        .add_res_v (add_res_v)
    );

    task automatic fill_range(input int r, input int first, input int last,
                              input logic [lane_w-1:0] v);
        for (int i = first; i <= last; i++) begin
            ops[r][i] = v;
        end
    endtask

    // plain sum of all 25 elements, wrapped to 16 bits
    function automatic logic [lane_w-1:0] row_sum(input int r);
        int unsigned acc;
        acc = 0;
        for (int i = 0; i < n_el; i++) begin
            acc = acc + 32'(ops[r][i]);
        end
        return acc[lane_w-1:0];
    endfunction

    function automatic int gap_total();
        int t;
        t = 0;
        for (int r = 0; r < num_rows; r++) begin
            t = t + gap[r];
        end
        return t;
    endfunction

    task automatic build_table();
        for (int r = 0; r < num_rows; r++) begin
            fill_range(r, 0, n_el - 1, '0);
            gap[r] = 0;
            issue_cyc[r] = -1;
        end
        // row 0 stays all zero
        gap[0] = 3;
        fill_range(1, 0, n_el - 1, 16'h0001);
        gap[1] = 3;
        // wraps well past 2^16
        fill_range(2, 0, n_el - 1, 16'hffff);
        // odd element on its own
        ops[3][24] = 16'h1234;
        gap[3] = 2;
        // low lane only, any carry leak would show up in the high lane
        fill_range(4, 0, 11, 16'hffff);
        fill_range(5, 12, 23, 16'h8001);
        gap[5] = 1;
        for (int i = 0; i < n_el; i++) begin
            ops[6][i] = lane_w'(i * 257 + 1);
        end
        ops[7][0] = 16'hffff;
        ops[7][24] = 16'h0001;
        gap[7] = 2;
        ops[8][12] = 16'habcd;
        fill_range(9, 0, 11, 16'hffff);
        ops[9][24] = 16'h0010;
        gap[9] = 3;
        // random rows go back to back
        for (int r = hand_rows; r < num_rows; r++) begin
            for (int i = 0; i < n_el; i++) begin
                ops[r][i] = lane_w'($urandom());
            end
        end
        for (int r = 0; r < num_rows; r++) begin
            exp_sum[r] = row_sum(r);
        end
    endtask

    // ***********************************************************************
    // checker
    // ***********************************************************************

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_result(input int r);
        int lat;
        lat = cycle - issue_cyc[r];
        if (add_res !== exp_sum[r]) begin
            $display("mismatch at %0d ns: row %0d expected %h got %h",
                     $time, r, exp_sum[r], add_res);
            errors++;
        end else if (lat != latency) begin
            $display("mismatch at %0d ns: row %0d latency expected %0d cycles got %0d",
                     $time, r, latency, lat);
            errors++;
        end else begin
            $display("row %0d ok, sum %h after %0d cycles", r, add_res, lat);
            passed++;
        end
    endtask

    // outputs are sampled mid-cycle, results must come in issue order
    always @(negedge clk) begin
        if (add_res_v) begin
            if (pulses >= issued) begin
                $display("unexpected result pulse at %0d ns with no row pending", $time);
                errors++;
            end else begin
                check_result(pulses);
            end
            pulses++;
        end
    end

    // ***********************************************************************
    // watchdog
    // ***********************************************************************

    initial begin : watchdog
        int limit_cyc;
        wait (table_ready);
        limit_cyc = rst_cyc + lead_idle + num_rows + gap_total() + latency + 20;
        #(limit_cyc * period);
        $display("timeout, the run did not finish within %0d cycles", limit_cyc);
        $display("Finished with errors");
        $finish;
    end

    // ***********************************************************************
    // driver and report
    // ***********************************************************************

    initial begin
        int drain;
        data_v = 1'b0;
        in_add = '0;
        void'($urandom(5824));
        build_table();
        table_ready = 1'b1;

        // idle stretch after reset, no pulse may appear here
        @(posedge rst);
        repeat (lead_idle) @(negedge clk);

        for (int r = 0; r < num_rows; r++) begin
            for (int i = 0; i < n_el; i++) begin
                in_add[i*lane_w +: lane_w] = ops[r][i];
            end
            data_v = 1'b1;
            issue_cyc[r] = cycle;
            issued++;
            @(negedge clk);
            data_v = 1'b0;
            repeat (gap[r]) @(negedge clk);
        end
        in_add = '0;

        drain = 0;
        while (pulses < num_rows && drain < drain_max) begin
            @(posedge clk);
            drain++;
        end
        // a few more cycles to catch stray pulses
        repeat (5) @(posedge clk);

        if (pulses != num_rows) begin
            $display("expected %0d result pulses but saw %0d", num_rows, pulses);
            errors++;
        end
        $display("rows %0d, passed %0d, pulses %0d, errors %0d",
                 num_rows, passed, pulses, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- project.f
rtl/adder_tree_pkg.sv
rtl/operand_capture.sv
rtl/lane_add_stage.sv
rtl/lane_fold.sv
rtl/adder_tree_25.sv
bench/clock_gen.sv
bench/adder_tree_25_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= adder_tree_25_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
